// ==== design/ip_eth_tx_pkg.sv ====
// ip_eth_tx shared protocol constants, field types, bus structs and sequencer states

package ip_eth_tx_pkg;

    // datapath geometry
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    // fixed ipv4 header fields, no options
    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL = 4'd5;

    // the 20 byte header leaves the payload 4 bytes off the word boundary
    localparam int SHIFT_BYTES = 4;
    localparam int HALF_W = SHIFT_BYTES * 8;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [KEEP_W-1:0] keep_t;
    typedef logic [47:0]       mac_addr_t;
    typedef logic [31:0]       ip_addr_t;
    typedef logic [15:0]       ether_type_t;
    typedef logic [15:0]       csum_t;

    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        ether_type_t eth_type;
    } eth_hdr_t;

    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        ip_addr_t    src_ip;
        ip_addr_t    dest_ip;
    } ip_hdr_t;

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
    } beat_t;

    typedef enum logic [2:0] {idle, hdr_word0, hdr_word1, hdr_word2, payload} seq_state_t;

endpackage

// ==== design/ip_hdr_checksum.sv ====
// ipv4 header checksum unit, sums the header words on load and holds the result

`timescale 1ns/1ps

module ip_hdr_checksum (
    input  logic                   clk,
    input  logic                   hdr_load,
    input  ip_eth_tx_pkg::ip_hdr_t ip_hdr,
    output ip_eth_tx_pkg::csum_t   csum
);

    // nine 16 bit words never exceed 20 bits
    logic [19:0] sum_d;
    logic [19:0] sum_q;
    logic [16:0] fold1;
    logic [15:0] fold2;

    // the checksum word itself counts as zero
    always_comb begin
        sum_d = 20'({ip_eth_tx_pkg::IP_VERSION, ip_eth_tx_pkg::IP_IHL,
                     ip_hdr.dscp, ip_hdr.ecn})
              + 20'(ip_hdr.length)
              + 20'(ip_hdr.identification)
              + 20'({ip_hdr.flags, ip_hdr.frag_offset})
              + 20'({ip_hdr.ttl, ip_hdr.protocol})
              + 20'(ip_hdr.src_ip[31:16])
              + 20'(ip_hdr.src_ip[15:0])
              + 20'(ip_hdr.dest_ip[31:16])
              + 20'(ip_hdr.dest_ip[15:0]);
    end

    // raw sum of the header being sent
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            sum_q <= sum_d;
        end
    end

    // end-around carry
    // first fold can still carry once more
    always_comb begin
        fold1 = 17'(sum_q[15:0]) + 17'(sum_q[19:16]);
        fold2 = fold1[15:0] + 16'(fold1[16]);
    end

    assign csum = ~fold2;

endmodule

// ==== design/payload_realign.sv ====
// payload realigner, moves the stream up by four bytes behind the ip header

`timescale 1ns/1ps

module payload_realign (
    input  logic                 clk,
    input  logic                 rst,
    input  ip_eth_tx_pkg::beat_t in_beat,
    input  logic                 in_valid,
    output logic                 in_ready,
    output ip_eth_tx_pkg::beat_t aln_beat,
    output logic                 aln_valid,
    input  logic                 aln_ready
);

    // upper half of the previous input beat
    logic [ip_eth_tx_pkg::HALF_W-1:0]      save_data;
    logic [ip_eth_tx_pkg::SHIFT_BYTES-1:0] save_keep;
    logic                                  save_last;
    // trailing beat still owed
    logic                                  extra_cycle;

    logic                                  in_xfer;
    logic                                  out_last_xfer;
    logic                                  upper_used;
    ip_eth_tx_pkg::keep_t                  keep_inc;

    assign upper_used = |in_beat.keep[ip_eth_tx_pkg::KEEP_W-1:ip_eth_tx_pkg::SHIFT_BYTES];

    // no input taken while the trailing beat is out
    assign in_ready = aln_ready && !extra_cycle;

    always_comb begin
        aln_beat.data[ip_eth_tx_pkg::HALF_W-1:0] = save_data;
        aln_beat.keep[ip_eth_tx_pkg::SHIFT_BYTES-1:0] = save_keep;
        if (extra_cycle) begin
            // saved half alone
            aln_beat.data[ip_eth_tx_pkg::DATA_W-1:ip_eth_tx_pkg::HALF_W] = '0;
            aln_beat.keep[ip_eth_tx_pkg::KEEP_W-1:ip_eth_tx_pkg::SHIFT_BYTES] = '0;
            aln_beat.last = save_last;
            aln_valid = 1'b1;
        end else begin
            aln_beat.data[ip_eth_tx_pkg::DATA_W-1:ip_eth_tx_pkg::HALF_W] =
                in_beat.data[ip_eth_tx_pkg::HALF_W-1:0];
            aln_beat.keep[ip_eth_tx_pkg::KEEP_W-1:ip_eth_tx_pkg::SHIFT_BYTES] =
                in_beat.keep[ip_eth_tx_pkg::SHIFT_BYTES-1:0];
            // ends here only if nothing spills into a trailing beat
            aln_beat.last = in_beat.last && !upper_used;
            aln_valid = in_valid;
        end
    end

    assign in_xfer = in_valid && in_ready;
    assign out_last_xfer = aln_valid && aln_ready && aln_beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            save_keep <= '0;
            save_last <= 1'b0;
            extra_cycle <= 1'b0;
        end else if (out_last_xfer) begin
            // frame done, next frame starts empty
            save_keep <= '0;
            save_last <= 1'b0;
            extra_cycle <= 1'b0;
        end else if (in_xfer) begin
            save_keep <= in_beat.keep[ip_eth_tx_pkg::KEEP_W-1:ip_eth_tx_pkg::SHIFT_BYTES];
            save_last <= in_beat.last;
            extra_cycle <= in_beat.last && upper_used;
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            save_data <= in_beat.data[ip_eth_tx_pkg::DATA_W-1:ip_eth_tx_pkg::HALF_W];
        end
    end

    // byte enables start at lane 0 with no holes
    assign keep_inc = in_beat.keep + 1'b1;

    keep_contiguous: assert property (
        @(posedge clk) disable iff (rst)
        in_valid |-> (in_beat.keep[0] && ((in_beat.keep & keep_inc) == '0))
    );

endmodule

// ==== design/ip_frame_sequencer.sv ====
// frame sequencer that takes the header and emits the ip header words and the realigned payload

`timescale 1ns/1ps

module ip_frame_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    hdr_valid,
    output logic                    hdr_ready,
    input  ip_eth_tx_pkg::eth_hdr_t in_eth,
    input  ip_eth_tx_pkg::ip_hdr_t  in_ip,
    output logic                    hdr_load,
    input  ip_eth_tx_pkg::csum_t    csum,
    output logic                    out_hdr_valid,
    input  logic                    out_hdr_ready,
    output ip_eth_tx_pkg::eth_hdr_t out_eth,
    input  ip_eth_tx_pkg::beat_t    aln_beat,
    input  logic                    aln_valid,
    output logic                    aln_ready,
    output ip_eth_tx_pkg::beat_t    buf_beat,
    output logic                    buf_valid,
    input  logic                    buf_ready,
    output logic                    busy
);

    ip_eth_tx_pkg::seq_state_t state_q;
    ip_eth_tx_pkg::seq_state_t state_d;

    ip_eth_tx_pkg::ip_hdr_t  ip_q;
    ip_eth_tx_pkg::eth_hdr_t eth_q;

    logic                    hdr_ready_q;
    logic                    hdr_ready_d;
    logic                    out_hdr_valid_q;
    logic                    out_hdr_valid_d;
    logic                    busy_q;
    logic                    hdr_accept;

    ip_eth_tx_pkg::data_t    word0;
    ip_eth_tx_pkg::data_t    word1;
    ip_eth_tx_pkg::data_t    word2;

    assign hdr_accept = hdr_valid && hdr_ready_q;
    assign hdr_load = hdr_accept;

    assign hdr_ready = hdr_ready_q;
    assign out_hdr_valid = out_hdr_valid_q;
    assign out_eth = eth_q;
    assign busy = busy_q;

    // header words in network order with the first byte on lane 0
    assign word0 = {ip_q.frag_offset[7:0], ip_q.flags, ip_q.frag_offset[12:8],
                    ip_q.identification[7:0], ip_q.identification[15:8],
                    ip_q.length[7:0], ip_q.length[15:8],
                    ip_q.dscp, ip_q.ecn,
                    ip_eth_tx_pkg::IP_VERSION, ip_eth_tx_pkg::IP_IHL};

    assign word1 = {ip_q.src_ip[7:0], ip_q.src_ip[15:8],
                    ip_q.src_ip[23:16], ip_q.src_ip[31:24],
                    csum[7:0], csum[15:8],
                    ip_q.protocol, ip_q.ttl};

    // dest ip shares its word with the first payload bytes
    assign word2 = {aln_beat.data[ip_eth_tx_pkg::DATA_W-1:ip_eth_tx_pkg::HALF_W],
                    ip_q.dest_ip[7:0], ip_q.dest_ip[15:8],
                    ip_q.dest_ip[23:16], ip_q.dest_ip[31:24]};

    always_comb begin
        state_d = state_q;
        out_hdr_valid_d = out_hdr_valid_q && !out_hdr_ready;
        aln_ready = 1'b0;
        buf_valid = 1'b0;
        buf_beat = aln_beat;

        unique case (state_q)
            ip_eth_tx_pkg::idle: begin
                if (hdr_accept) begin
                    out_hdr_valid_d = 1'b1;
                    state_d = ip_eth_tx_pkg::hdr_word0;
                end
            end
            ip_eth_tx_pkg::hdr_word0: begin
                buf_beat.data = word0;
                buf_beat.keep = '1;
                buf_beat.last = 1'b0;
                if (buf_ready) begin
                    buf_valid = 1'b1;
                    state_d = ip_eth_tx_pkg::hdr_word1;
                end
            end
            ip_eth_tx_pkg::hdr_word1: begin
                // csum settled one cycle after load
                buf_beat.data = word1;
                buf_beat.keep = '1;
                buf_beat.last = 1'b0;
                if (buf_ready) begin
                    buf_valid = 1'b1;
                    state_d = ip_eth_tx_pkg::hdr_word2;
                end
            end
            ip_eth_tx_pkg::hdr_word2: begin
                aln_ready = buf_ready;
                buf_beat.data = word2;
                buf_beat.keep = {aln_beat.keep[ip_eth_tx_pkg::KEEP_W-1:ip_eth_tx_pkg::SHIFT_BYTES],
                                 {ip_eth_tx_pkg::SHIFT_BYTES{1'b1}}};
                buf_beat.last = aln_beat.last;
                if (buf_ready && aln_valid) begin
                    buf_valid = 1'b1;
                    state_d = aln_beat.last ? ip_eth_tx_pkg::idle : ip_eth_tx_pkg::payload;
                end
            end
            ip_eth_tx_pkg::payload: begin
                aln_ready = buf_ready;
                if (buf_ready && aln_valid) begin
                    buf_valid = 1'b1;
                    if (aln_beat.last) begin
                        state_d = ip_eth_tx_pkg::idle;
                    end
                end
            end
            default: begin
                state_d = ip_eth_tx_pkg::idle;
            end
        endcase

        // next header only once the eth header has gone out
        hdr_ready_d = (state_d == ip_eth_tx_pkg::idle) && !out_hdr_valid_d;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ip_eth_tx_pkg::idle;
            hdr_ready_q <= 1'b0;
            out_hdr_valid_q <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            state_q <= state_d;
            hdr_ready_q <= hdr_ready_d;
            out_hdr_valid_q <= out_hdr_valid_d;
            busy_q <= state_d != ip_eth_tx_pkg::idle;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            ip_q <= in_ip;
            eth_q <= in_eth;
        end
    end

    // header registers and csum stay put until the frame is done
    load_only_between_frames: assert property (
        @(posedge clk) disable iff (rst)
        hdr_load |-> ((state_q == ip_eth_tx_pkg::idle) && !out_hdr_valid_q)
    );

endmodule

// ==== design/axis_out_buffer.sv ====
// output skid buffer, output register plus one spare entry behind a registered ready

`timescale 1ns/1ps

module axis_out_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  ip_eth_tx_pkg::beat_t buf_beat,
    input  logic                 buf_valid,
    output logic                 buf_ready,
    output ip_eth_tx_pkg::beat_t out_beat,
    output logic                 out_valid,
    input  logic                 out_ready
);

    ip_eth_tx_pkg::beat_t out_q;
    ip_eth_tx_pkg::beat_t temp_q;
    logic                 out_valid_q;
    logic                 out_valid_d;
    logic                 temp_valid_q;
    logic                 temp_valid_d;
    logic                 ready_q;
    logic                 ready_early;
    logic                 in_to_out;
    logic                 in_to_temp;
    logic                 temp_to_out;

    assign buf_ready = ready_q;
    assign out_beat = out_q;
    assign out_valid = out_valid_q;

    // ready next cycle unless the spare entry could fill up
    assign ready_early = out_ready || (!temp_valid_q && (!out_valid_q || !buf_valid));

    always_comb begin
        out_valid_d = out_valid_q;
        temp_valid_d = temp_valid_q;
        in_to_out = 1'b0;
        in_to_temp = 1'b0;
        temp_to_out = 1'b0;
        if (ready_q) begin
            if (out_ready || !out_valid_q) begin
                out_valid_d = buf_valid;
                in_to_out = 1'b1;
            end else begin
                // output stalled
                temp_valid_d = buf_valid;
                in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_d = temp_valid_q;
            temp_valid_d = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
            temp_valid_q <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            out_valid_q <= out_valid_d;
            temp_valid_q <= temp_valid_d;
            ready_q <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_q <= buf_beat;
        end else if (temp_to_out) begin
            out_q <= temp_q;
        end
        if (in_to_temp) begin
            temp_q <= buf_beat;
        end
    end

    temp_no_overwrite: assert property (
        @(posedge clk) disable iff (rst)
        (in_to_temp && buf_valid) |-> !temp_valid_q
    );

endmodule

// ==== design/ip_eth_tx.sv ====
// ipv4 over ethernet transmitter top, 64 bit datapath

`timescale 1ns/1ps

module ip_eth_tx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    hdr_valid,
    output logic                    hdr_ready,
    input  ip_eth_tx_pkg::eth_hdr_t in_eth,
    input  ip_eth_tx_pkg::ip_hdr_t  in_ip,
    input  ip_eth_tx_pkg::beat_t    in_beat,
    input  logic                    in_valid,
    output logic                    in_ready,
    output logic                    out_hdr_valid,
    input  logic                    out_hdr_ready,
    output ip_eth_tx_pkg::eth_hdr_t out_eth,
    output ip_eth_tx_pkg::beat_t    out_beat,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    busy
);

    logic                 hdr_load;
    ip_eth_tx_pkg::csum_t csum;

    // realigned payload into the sequencer
    ip_eth_tx_pkg::beat_t aln_beat;
    logic                 aln_valid;
    logic                 aln_ready;

    // sequencer into the output buffer
    ip_eth_tx_pkg::beat_t buf_beat;
    logic                 buf_valid;
    logic                 buf_ready;

    ip_hdr_checksum csum0 (
        .clk      (clk),
        .hdr_load (hdr_load),
        .ip_hdr   (in_ip),
        .csum     (csum)
    );

    payload_realign aln0 (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .aln_beat  (aln_beat),
        .aln_valid (aln_valid),
        .aln_ready (aln_ready)
    );

    ip_frame_sequencer seq0 (
        .clk           (clk),
        .rst           (rst),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .in_eth        (in_eth),
        .in_ip         (in_ip),
        .hdr_load      (hdr_load),
        .csum          (csum),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_eth       (out_eth),
        .aln_beat      (aln_beat),
        .aln_valid     (aln_valid),
        .aln_ready     (aln_ready),
        .buf_beat      (buf_beat),
        .buf_valid     (buf_valid),
        .buf_ready     (buf_ready),
        .busy          (busy)
    );

    axis_out_buffer obuf0 (
        .clk       (clk),
        .rst       (rst),
        .buf_beat  (buf_beat),
        .buf_valid (buf_valid),
        .buf_ready (buf_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
// testbench clock and reset source, 10 ns clock with reset held for three cycles

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // released just after the third rising edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== dv/ip_eth_tx_tb.sv ====
// ipv4 frame transmitter testbench with random frames checked against a byte model

`timescale 1ns/1ps

module ip_eth_tx_tb;

    localparam int NUM_FRAMES = 40;
    localparam int MAX_PAY = 40;
    localparam int HDR_BYTES = 20;
    localparam int WAIT_LIMIT = 2000;
    localparam int RUN_LIMIT = 50000;

    logic                    clk;
    logic                    rst;
    logic                    hdr_valid;
    logic                    hdr_ready;
    ip_eth_tx_pkg::eth_hdr_t in_eth;
    ip_eth_tx_pkg::ip_hdr_t  in_ip;
    ip_eth_tx_pkg::beat_t    in_beat;
    logic                    in_valid;
    logic                    in_ready;
    logic                    out_hdr_valid;
    logic                    out_hdr_ready;
    ip_eth_tx_pkg::eth_hdr_t out_eth;
    ip_eth_tx_pkg::beat_t    out_beat;
    logic                    out_valid;
    logic                    out_ready;
    logic                    busy;

    // frames to send and the wire bytes expected for each
    ip_eth_tx_pkg::eth_hdr_t frame_eth [NUM_FRAMES];
    ip_eth_tx_pkg::ip_hdr_t  frame_ip [NUM_FRAMES];
    int                      pay_len [NUM_FRAMES];
    logic [7:0]              exp_bytes [NUM_FRAMES][HDR_BYTES+MAX_PAY];

    int                      check_errors;
    int                      timeout_errors;
    int                      hdr_count;
    int                      eth_seen;
    int                      frames_done;
    int                      out_pos;
    int                      out_beats;
    bit                      checking;
    bit                      abort;
    bit                      run_done;
    bit                      busy_due;
    bit                      prev_out_stall;
    bit                      prev_hdr_stall;
    ip_eth_tx_pkg::beat_t    prev_beat;
    ip_eth_tx_pkg::eth_hdr_t prev_eth;

    tb_clk_gen clk_gen0 (
        .clk (clk),
        .rst (rst)
    );

    ip_eth_tx dut0 (
        .clk           (clk),
        .rst           (rst),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .in_eth        (in_eth),
        .in_ip         (in_ip),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_eth       (out_eth),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .busy          (busy)
    );

    task automatic log_mismatch(input string msg);
        check_errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic log_timeout(input string msg);
        timeout_errors++;
        abort = 1'b1;
        $display("timeout at %0t ns: %s", $time, msg);
    endtask

    task automatic build_frames();
        int                     f;
        int                     i;
        logic [31:0]            r0;
        logic [31:0]            r1;
        logic [31:0]            r2;
        logic [31:0]            r3;
        logic [31:0]            sum;
        ip_eth_tx_pkg::ip_hdr_t ip;
        for (f = 0; f < NUM_FRAMES; f++) begin
            r0 = $urandom;
            r1 = $urandom;
            r2 = $urandom;
            r3 = $urandom;
            frame_eth[f].dest_mac = {r0[15:0], r1};
            frame_eth[f].src_mac = {r2[15:0], r3};
            frame_eth[f].eth_type = r0[31:16];
            pay_len[f] = $urandom_range(1, MAX_PAY);
            r0 = $urandom;
            r1 = $urandom;
            ip.dscp = r0[5:0];
            ip.ecn = r0[7:6];
            ip.length = 16'(HDR_BYTES + pay_len[f]);
            ip.identification = r0[31:16];
            ip.flags = r1[2:0];
            ip.frag_offset = r1[15:3];
            ip.ttl = r1[23:16];
            ip.protocol = r1[31:24];
            ip.src_ip = $urandom;
            ip.dest_ip = $urandom;
            frame_ip[f] = ip;
            // header on the wire with version 4 and ihl 5 first
            exp_bytes[f][0] = {4'd4, 4'd5};
            exp_bytes[f][1] = {ip.dscp, ip.ecn};
            exp_bytes[f][2] = ip.length[15:8];
            exp_bytes[f][3] = ip.length[7:0];
            exp_bytes[f][4] = ip.identification[15:8];
            exp_bytes[f][5] = ip.identification[7:0];
            exp_bytes[f][6] = {ip.flags, ip.frag_offset[12:8]};
            exp_bytes[f][7] = ip.frag_offset[7:0];
            exp_bytes[f][8] = ip.ttl;
            exp_bytes[f][9] = ip.protocol;
            exp_bytes[f][10] = 8'h00;
            exp_bytes[f][11] = 8'h00;
            for (i = 0; i < 4; i++) begin
                exp_bytes[f][12+i] = ip.src_ip[31-8*i -: 8];
                exp_bytes[f][16+i] = ip.dest_ip[31-8*i -: 8];
            end
            // one's complement sum over the ten big endian words
            sum = '0;
            for (i = 0; i < 10; i++) begin
                sum += {exp_bytes[f][2*i], exp_bytes[f][2*i+1]};
            end
            while (sum[31:16] != 0) begin
                sum = sum[15:0] + sum[31:16];
            end
            exp_bytes[f][10] = ~sum[15:8];
            exp_bytes[f][11] = ~sum[7:0];
            for (i = 0; i < pay_len[f]; i++) begin
                exp_bytes[f][HDR_BYTES+i] = 8'($urandom);
            end
        end
    endtask

    task automatic drive_headers();
        int f;
        int waited;
        bit took;
        for (f = 0; f < NUM_FRAMES && !abort; f++) begin
            repeat ($urandom_range(0, 3)) begin
                @(posedge clk);
                #1;
            end
            hdr_valid = 1'b1;
            in_eth = frame_eth[f];
            in_ip = frame_ip[f];
            took = 1'b0;
            waited = 0;
            while (!took && waited < WAIT_LIMIT) begin
                @(posedge clk);
                took = hdr_ready;
                waited++;
            end
            #1;
            hdr_valid = 1'b0;
            if (!took) begin
                log_timeout($sformatf("header of frame %0d was never accepted", f));
            end
        end
    endtask

    task automatic drive_payload();
        int f;
        int pos;
        int lane;
        int waited;
        bit took;
        for (f = 0; f < NUM_FRAMES && !abort; f++) begin
            pos = 0;
            while (pos < pay_len[f] && !abort) begin
                if ($urandom_range(0, 3) == 0) begin
                    @(posedge clk);
                    #1;
                end
                // lanes past the payload carry junk with keep clear
                for (lane = 0; lane < 8; lane++) begin
                    if (pos + lane < pay_len[f]) begin
                        in_beat.data[8*lane +: 8] = exp_bytes[f][HDR_BYTES+pos+lane];
                        in_beat.keep[lane] = 1'b1;
                    end else begin
                        in_beat.data[8*lane +: 8] = 8'($urandom);
                        in_beat.keep[lane] = 1'b0;
                    end
                end
                pos += 8;
                in_beat.last = pos >= pay_len[f];
                in_valid = 1'b1;
                took = 1'b0;
                waited = 0;
                while (!took && waited < WAIT_LIMIT) begin
                    @(posedge clk);
                    took = in_ready;
                    waited++;
                end
                #1;
                in_valid = 1'b0;
                if (!took) begin
                    log_timeout($sformatf("payload beat of frame %0d was never accepted", f));
                end
            end
        end
    endtask

    task automatic drive_ready();
        int cyc;
        for (cyc = 0; cyc < RUN_LIMIT && !run_done; cyc++) begin
            @(posedge clk);
            #1;
            out_ready = $urandom_range(0, 9) < 6;
            out_hdr_ready = $urandom_range(0, 1) == 1;
        end
    endtask

    task automatic check_out_beat();
        int         total;
        int         remaining;
        int         take;
        int         lane;
        logic [7:0] exp_keep;
        logic       exp_last;
        if (frames_done >= NUM_FRAMES) begin
            log_mismatch("output beat after the last frame");
        end else begin
            total = HDR_BYTES + pay_len[frames_done];
            remaining = total - out_pos;
            if (remaining > 8) begin
                take = 8;
            end else if (remaining > 0) begin
                take = remaining;
            end else begin
                take = 0;
            end
            exp_keep = 8'((1 << take) - 1);
            exp_last = remaining <= 8;
            out_beats++;
            if (out_beat.keep !== exp_keep) begin
                log_mismatch($sformatf("frame %0d keep %h expected %h",
                                       frames_done, out_beat.keep, exp_keep));
            end
            if (out_beat.last !== exp_last) begin
                log_mismatch($sformatf("frame %0d last %b expected %b",
                                       frames_done, out_beat.last, exp_last));
            end
            for (lane = 0; lane < take; lane++) begin
                if (out_beat.data[8*lane +: 8] !== exp_bytes[frames_done][out_pos+lane]) begin
                    log_mismatch($sformatf("frame %0d byte %0d is %h expected %h",
                                           frames_done, out_pos + lane,
                                           out_beat.data[8*lane +: 8],
                                           exp_bytes[frames_done][out_pos+lane]));
                end
            end
            out_pos += take;
            // a frame ends where the dut marks its last beat
            if (out_beat.last === 1'b1) begin
                if (out_beats != (total + 7) / 8) begin
                    log_mismatch($sformatf("frame %0d took %0d beats expected %0d",
                                           frames_done, out_beats, (total + 7) / 8));
                end
                // the last beat was pushed earlier so only a newer header keeps busy up
                if (busy !== (hdr_count > frames_done + 1)) begin
                    log_mismatch($sformatf("busy %b at end of frame %0d", busy, frames_done));
                end
                frames_done++;
                out_pos = 0;
                out_beats = 0;
            end
        end
    endtask

    always @(posedge clk) begin : monitor
        if (checking) begin
            if (prev_out_stall && (out_valid !== 1'b1 || out_beat !== prev_beat)) begin
                log_mismatch("out_beat did not hold while stalled");
            end
            if (prev_hdr_stall && (out_hdr_valid !== 1'b1 || out_eth !== prev_eth)) begin
                log_mismatch("out_eth did not hold while stalled");
            end
            if (busy_due && busy !== 1'b1) begin
                log_mismatch("busy low after a header transfer");
            end
            busy_due = 1'b0;
            if (out_hdr_valid && out_hdr_ready) begin
                if (eth_seen >= NUM_FRAMES) begin
                    log_mismatch("output header after the last frame");
                end else if (out_eth !== frame_eth[eth_seen]) begin
                    log_mismatch($sformatf("eth header %0d is %h expected %h",
                                           eth_seen, out_eth, frame_eth[eth_seen]));
                end
                eth_seen++;
            end
            if (out_valid && out_ready) begin
                check_out_beat();
            end
            // header transfers counted after the frame end check of this edge
            if (hdr_valid && hdr_ready) begin
                hdr_count++;
                busy_due = 1'b1;
            end
            prev_out_stall = out_valid && !out_ready;
            prev_hdr_stall = out_hdr_valid && !out_hdr_ready;
            prev_beat = out_beat;
            prev_eth = out_eth;
        end
    end

    initial begin : main
        int cyc;
        int seed;
        bit seen;
        seed = $urandom(98);
        check_errors = 0;
        timeout_errors = 0;
        hdr_count = 0;
        eth_seen = 0;
        frames_done = 0;
        out_pos = 0;
        out_beats = 0;
        checking = 1'b0;
        abort = 1'b0;
        run_done = 1'b0;
        busy_due = 1'b0;
        prev_out_stall = 1'b0;
        prev_hdr_stall = 1'b0;
        hdr_valid = 1'b0;
        in_eth = '0;
        in_ip = '0;
        in_beat = '0;
        in_valid = 1'b0;
        out_hdr_ready = 1'b0;
        out_ready = 1'b0;
        build_frames();

        cyc = 0;
        while (rst !== 1'b0 && cyc < 20) begin
            @(posedge clk);
            cyc++;
        end
        if (rst !== 1'b0) begin
            log_timeout("reset was never released");
        end else begin
            if (out_valid !== 1'b0 || out_hdr_valid !== 1'b0 || busy !== 1'b0) begin
                log_mismatch("outputs not idle after reset");
            end
            seen = 1'b0;
            cyc = 0;
            while (!seen && cyc < 5) begin
                @(posedge clk);
                seen = hdr_ready === 1'b1;
                cyc++;
            end
            if (!seen) begin
                log_mismatch("hdr_ready not high within 5 cycles of reset");
            end
            #1;
            checking = 1'b1;
            fork
                drive_headers();
                drive_payload();
                drive_ready();
            join_none

            cyc = 0;
            while (frames_done < NUM_FRAMES && !abort && cyc < RUN_LIMIT) begin
                @(posedge clk);
                cyc++;
            end
            if (frames_done < NUM_FRAMES && !abort) begin
                log_timeout($sformatf("only %0d frames came out", frames_done));
            end
            cyc = 0;
            while (eth_seen < NUM_FRAMES && !abort && cyc < WAIT_LIMIT) begin
                @(posedge clk);
                cyc++;
            end
            if (eth_seen < NUM_FRAMES && !abort) begin
                log_timeout($sformatf("only %0d ethernet headers came out", eth_seen));
            end
            if (busy !== 1'b0) begin
                log_mismatch("busy still high after the last frame");
            end
        end

        run_done = 1'b1;
        $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== ip_eth_tx.f ====
design/ip_eth_tx_pkg.sv
design/ip_hdr_checksum.sv
design/payload_realign.sv
design/ip_frame_sequencer.sv
design/axis_out_buffer.sv
design/ip_eth_tx.sv
dv/tb_clk_gen.sv
dv/ip_eth_tx_tb.sv

// ==== Bender.yml ====
package:
  name: ip_eth_tx

sources:
  - design/ip_eth_tx_pkg.sv
  - design/ip_hdr_checksum.sv
  - design/payload_realign.sv
  - design/ip_frame_sequencer.sv
  - design/axis_out_buffer.sv
  - design/ip_eth_tx.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/ip_eth_tx_tb.sv
